// File: rs_settings.svh
// ALU reservation station sizes, field widths and the initial issue credits.
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// six entries, addressed by a three-bit entry tag.
`define RS_SIZE 6
`define RS_TAG_WIDTH 3

// entry-tag code returned when every entry is busy.
`define NO_FREE_TAG {`RS_TAG_WIDTH{1'b1}}

// producer tags carried on the common data bus.
`define SRC_TAG_WIDTH 4

// operand and result width.
`define DATA_WIDTH 32

// ALU opcode width.
`define OP_WIDTH 4

// issue slots the ALU grants after reset.
`define ISSUE_CREDITS 2

`endif

// File: rsPkg.sv
// reservation station types for operands, dispatch, CDB, issue and entry records.
`include "rs_settings.svh"

package rsPkg;

        typedef logic [`RS_TAG_WIDTH-1:0] entryTagT;

        // tag view of an operand word whose producer is still in flight.
        typedef struct packed {
                logic [`DATA_WIDTH-`SRC_TAG_WIDTH-1:0] pad;
                logic [`SRC_TAG_WIDTH-1:0]             tag;
        } tagViewT;

        typedef union packed {
                logic [`DATA_WIDTH-1:0] data;
                tagViewT                tagView;
        } operandT;

        // ready selects which view of the operand word holds.
        typedef struct packed {
                logic    ready;
                operandT operand;
        } srcT;

        typedef struct packed {
                logic [`OP_WIDTH-1:0]      op;
                srcT                       srcA;
                srcT                       srcB;
                logic [`SRC_TAG_WIDTH-1:0] destTag;
        } dispatchT;

        typedef struct packed {
                logic                      valid;
                logic [`SRC_TAG_WIDTH-1:0] tag;
                logic [`DATA_WIDTH-1:0]    value;
        } cdbT;

        typedef struct packed {
                logic [`OP_WIDTH-1:0]      op;
                logic [`DATA_WIDTH-1:0]    valueA;
                logic [`DATA_WIDTH-1:0]    valueB;
                logic [`SRC_TAG_WIDTH-1:0] destTag;
        } issueT;

        typedef struct packed {
                logic     busy;
                dispatchT payload;
        } entryT;

endpackage

// File: freeTagTable.sv
// free-tag table: maps the busy vector to the lowest free entry of the station.
`timescale 1ns/100ps
`include "rs_settings.svh"

module freeTagTable (
        input  logic                rst,
        input  logic                rstN,
        input  logic [`RS_SIZE-1:0] busy,
        output rsPkg::entryTagT     freeTag
);
        import rsPkg::*;

        localparam int TableDepth = 1 << `RS_SIZE;

        // one tag per free-status word.
        entryTagT lookup [TableDepth];

        // returns the index of the lowest set bit, or the no-free code.
        function automatic entryTagT lowestFree(input logic [`RS_SIZE-1:0] freeStatus);
                entryTagT tag;
                tag = `NO_FREE_TAG;
                for (int j = `RS_SIZE - 1; j >= 0; j--) begin
                        if (freeStatus[j]) begin
                                tag = entryTagT'(j);
                        end
                end
                return tag;
        endfunction

        ////////////////////////////////////////
        // table load

        // the table is written once while reset is held and is read-only after.
        always_ff @(posedge rst) begin
                if (!rstN) begin
                        for (int i = 0; i < TableDepth; i++) begin
                                lookup[i] <= lowestFree(i[`RS_SIZE-1:0]);
                        end
                end
        end

        ////////////////////////////////////////
        // lookup

        assign freeTag = lookup[~busy];

endmodule

// File: readyPicker.sv
// ready picker: fixed-priority choice of the lowest-index entry with both operands ready.
`timescale 1ns/100ps
`include "rs_settings.svh"

module readyPicker (
        input  logic [`RS_SIZE-1:0] ready,
        output logic                pickValid,
        output rsPkg::entryTagT     pickTag
);
        import rsPkg::*;

        entryTagT lowestReady;
        logic     anyReady;

        // scanning from the top lets the lowest ready index win.
        always_comb begin
                anyReady    = 1'b0;
                lowestReady = '0;
                for (int i = `RS_SIZE - 1; i >= 0; i--) begin
                        if (ready[i]) begin
                                anyReady    = 1'b1;
                                lowestReady = entryTagT'(i);
                        end
                end
        end

        assign pickValid = anyReady;
        assign pickTag   = lowestReady;

endmodule

// File: rsArray.sv
// reservation station entry array with CDB wakeup, allocation, issue and credit counting.
`timescale 1ns/100ps
`include "rs_settings.svh"

module rsArray (
        input  logic                rst,
        input  logic                rstN,
        input  logic                dispatchValid,
        input  rsPkg::dispatchT     dispatch,
        input  rsPkg::cdbT          cdb,
        input  rsPkg::entryTagT     freeTag,
        input  logic                pickValid,
        input  rsPkg::entryTagT     pickTag,
        output logic [`RS_SIZE-1:0] busy,
        output logic [`RS_SIZE-1:0] ready,
        output logic                dispatchCredit,
        input  logic                issueCreditReturn,
        output logic                issueValid,
        output rsPkg::issueT        issue
);
        import rsPkg::*;

        localparam int CreditWidth = $clog2(`ISSUE_CREDITS + 1);

        entryT                  entries [`RS_SIZE];
        entryT                  pickedEntry;
        logic [CreditWidth-1:0] issueCredits;
        logic                   doIssue;

        // captures the CDB value into a waiting source whose tag matches.
        function automatic srcT wake(input srcT src, input cdbT bus);
                srcT result;
                result = src;
                if (!src.ready && bus.valid && bus.tag == src.operand.tagView.tag) begin
                        result.ready        = 1'b1;
                        result.operand.data = bus.value;
                end
                return result;
        endfunction

        ////////////////////////////////////////
        // entry storage

        // a dispatch lands in the free slot with the CDB forwarded into it;
        // an issued slot is released at the same edge that registers the issue.
        always_ff @(posedge rst) begin
                for (int i = 0; i < `RS_SIZE; i++) begin
                        if (!rstN) begin
                                entries[i].busy <= 1'b0;
                        end else if (dispatchValid && freeTag == entryTagT'(i)) begin
                                entries[i].busy            <= 1'b1;
                                entries[i].payload.op      <= dispatch.op;
                                entries[i].payload.destTag <= dispatch.destTag;
                                entries[i].payload.srcA    <= wake(dispatch.srcA, cdb);
                                entries[i].payload.srcB    <= wake(dispatch.srcB, cdb);
                        end else if (doIssue && pickTag == entryTagT'(i)) begin
                                entries[i].busy <= 1'b0;
                        end else if (entries[i].busy) begin
                                entries[i].payload.srcA <= wake(entries[i].payload.srcA, cdb);
                                entries[i].payload.srcB <= wake(entries[i].payload.srcB, cdb);
                        end
                end
        end

        always_comb begin
                for (int i = 0; i < `RS_SIZE; i++) begin
                        busy[i]  = entries[i].busy;
                        ready[i] = entries[i].busy
                                   && entries[i].payload.srcA.ready
                                   && entries[i].payload.srcB.ready;
                end
        end

        ////////////////////////////////////////
        // issue

        assign doIssue     = pickValid && (issueCredits != '0);
        assign pickedEntry = entries[pickTag];

        // the freed entry hands one credit back to the dispatcher.
        always_ff @(posedge rst) begin
                if (!rstN) begin
                        issueValid     <= 1'b0;
                        dispatchCredit <= 1'b0;
                end else begin
                        issueValid     <= doIssue;
                        dispatchCredit <= doIssue;
                end
        end

        always_ff @(posedge rst) begin
                if (doIssue) begin
                        issue.op      <= pickedEntry.payload.op;
                        issue.valueA  <= pickedEntry.payload.srcA.operand.data;
                        issue.valueB  <= pickedEntry.payload.srcB.operand.data;
                        issue.destTag <= pickedEntry.payload.destTag;
                end
        end

        ////////////////////////////////////////
        // issue credits

        // a return in the same cycle as an issue leaves the count as it is.
        always_ff @(posedge rst) begin
                if (!rstN) begin
                        issueCredits <= CreditWidth'(`ISSUE_CREDITS);
                end else if (doIssue && !issueCreditReturn) begin
                        issueCredits <= issueCredits - 1'b1;
                end else if (!doIssue && issueCreditReturn) begin
                        issueCredits <= issueCredits + 1'b1;
                end
        end

endmodule

// File: rsTop.sv
// ALU reservation station top: free-tag table, ready picker and entry array.
`timescale 1ns/100ps
`include "rs_settings.svh"

module rsTop (
        input  logic            rst,
        input  logic            rstN,
        input  logic            dispatchValid,
        input  rsPkg::dispatchT dispatch,
        output logic            dispatchCredit,
        input  rsPkg::cdbT      cdb,
        output logic            issueValid,
        output rsPkg::issueT    issue,
        input  logic            issueCreditReturn
);
        import rsPkg::*;

        logic [`RS_SIZE-1:0] busy;
        logic [`RS_SIZE-1:0] ready;
        entryTagT            freeTag;
        entryTagT            pickTag;
        logic                pickValid;

        // the table and the picker run side by side on the array state.
        freeTagTable uFreeTagTable (
                .rst     (rst),
                .rstN    (rstN),
                .busy    (busy),
                .freeTag (freeTag)
        );

        readyPicker uReadyPicker (
                .ready     (ready),
                .pickValid (pickValid),
                .pickTag   (pickTag)
        );

        rsArray uArray (
                .rst               (rst),
                .rstN              (rstN),
                .dispatchValid     (dispatchValid),
                .dispatch          (dispatch),
                .cdb               (cdb),
                .freeTag           (freeTag),
                .pickValid         (pickValid),
                .pickTag           (pickTag),
                .busy              (busy),
                .ready             (ready),
                .dispatchCredit    (dispatchCredit),
                .issueCreditReturn (issueCreditReturn),
                .issueValid        (issueValid),
                .issue             (issue)
        );

endmodule

// File: tbClock.sv
// testbench clock and reset generator: 20 ns clock, reset held low for two cycles.
`timescale 1ns/100ps

module tbClock (
        output logic rst,
        output logic rstN
);
        initial begin
                rst = 1'b0;
                forever #10 rst = ~rst;
        end

        // release on a falling edge so the first active edge sees a stable reset.
        initial begin
                rstN = 1'b0;
                repeat (2) @(posedge rst);
                @(negedge rst);
                rstN = 1'b1;
        end

endmodule

// File: rs_props.sv
// reservation station properties: reset state, issue credits, dispatch flow control, credit pulses.
`timescale 1ns/100ps
`include "rs_settings.svh"

module rsProps (
        input logic                                  rst,
        input logic                                  rstN,
        input logic                                  dispatchValid,
        input logic                                  dispatchCredit,
        input logic                                  issueValid,
        input logic [`RS_SIZE-1:0]                   busy,
        input logic [$clog2(`ISSUE_CREDITS + 1)-1:0] issueCredits
);

        issueIdleAfterReset: assert property (@(posedge rst) !rstN |=> !issueValid)
                else $error("issueValid was high in the cycle after a reset edge");

        noIssueWithoutCredit: assert property (@(posedge rst) disable iff (!rstN)
                        issueCredits == '0 |=> !issueValid)
                else $error("an instruction issued while the issue credit count was zero");

        noDispatchWhenFull: assert property (@(posedge rst) disable iff (!rstN)
                        dispatchValid |-> !(&busy))
                else $error("a dispatch arrived while every entry was busy");

        // each entry freed at an edge hands back exactly one credit in the cycle after it.
        creditPerFreedEntry: assert property (@(posedge rst) disable iff (!rstN)
                        $countones(busy) + dispatchCredit
                        == $countones($past(busy)) + $past(dispatchValid))
                else $error("dispatchCredit pulses do not match the entries freed by issue");

endmodule

bind rsTop rsProps uProps (
        .rst            (rst),
        .rstN           (rstN),
        .dispatchValid  (dispatchValid),
        .dispatchCredit (dispatchCredit),
        .issueValid     (issueValid),
        .busy           (busy),
        .issueCredits   (uArray.issueCredits)
);

// File: rsTb.sv
// reservation station testbench: table-driven stimulus checked against a cycle model.
`timescale 1ns/100ps
`include "rs_settings.svh"

module rsTb;
        import rsPkg::*;

        logic     rst;
        logic     rstN;
        logic     dispatchValid;
        dispatchT dispatch;
        logic     dispatchCredit;
        cdbT      cdb;
        logic     issueValid;
        issueT    issue;
        logic     issueCreditReturn;

        // stimulus table, one step per clock cycle.
        string    stepName [$];
        logic     stepValid [$];
        dispatchT stepDispatch [$];
        cdbT      stepCdb [$];
        logic     stepReturn [$];
        logic     tableBuilt;

        // cycle model of the station.
        logic     mBusy [`RS_SIZE];
        dispatchT mEntry [`RS_SIZE];
        int       mCredits;
        logic     expValid;
        issueT    expIssue;

        int errors;
        int tests;
        int issuesSeen;
        int issuesExpected;
        int pulsesSeen;
        int returnsSent;
        int dispatcherCredits;
        int minDispatchCredits;

        tbClock uClock (
                .rst  (rst),
                .rstN (rstN)
        );

        rsTop u_dut (
                .rst               (rst),
                .rstN              (rstN),
                .dispatchValid     (dispatchValid),
                .dispatch          (dispatch),
                .dispatchCredit    (dispatchCredit),
                .cdb               (cdb),
                .issueValid        (issueValid),
                .issue             (issue),
                .issueCreditReturn (issueCreditReturn)
        );

        ////////////////////////////////////////
        // stimulus helpers

        function automatic srcT readySrc(input logic [`DATA_WIDTH-1:0] value);
                srcT s;
                s.ready        = 1'b1;
                s.operand.data = value;
                return s;
        endfunction

        function automatic srcT waitSrc(input logic [`SRC_TAG_WIDTH-1:0] tag);
                srcT s;
                s.ready               = 1'b0;
                s.operand.data        = '0;
                s.operand.tagView.tag = tag;
                return s;
        endfunction

        function automatic dispatchT instr(input logic [`OP_WIDTH-1:0] op, input srcT a,
                                           input srcT b, input logic [`SRC_TAG_WIDTH-1:0] dest);
                dispatchT d;
                d.op      = op;
                d.srcA    = a;
                d.srcB    = b;
                d.destTag = dest;
                return d;
        endfunction

        function automatic cdbT bus(input logic [`SRC_TAG_WIDTH-1:0] tag,
                                    input logic [`DATA_WIDTH-1:0] value);
                cdbT c;
                c.valid = 1'b1;
                c.tag   = tag;
                c.value = value;
                return c;
        endfunction

        // a waiting source takes the value of a valid CDB word that carries its tag.
        function automatic srcT snoop(input srcT s, input cdbT c);
                srcT r;
                r = s;
                if (!s.ready && c.valid && c.tag == s.operand.tagView.tag) begin
                        r.ready        = 1'b1;
                        r.operand.data = c.value;
                end
                return r;
        endfunction

        task automatic addStep(input string name, input logic valid, input dispatchT d,
                               input cdbT c, input logic ret);
                stepName.push_back(name);
                stepValid.push_back(valid);
                stepDispatch.push_back(d);
                stepCdb.push_back(c);
                stepReturn.push_back(ret);
        endtask

        task automatic buildTable();
                addStep("ready", 1, instr(1, readySrc($urandom), readySrc($urandom), 1), '0, 0);
                addStep("ready", 1, instr(2, readySrc($urandom), readySrc($urandom), 2), '0, 1);
                addStep("ready", 1, instr(3, readySrc($urandom), readySrc($urandom), 3), '0, 1);
                addStep("wakeup", 1, instr(4, waitSrc(5), readySrc($urandom), 4), '0, 0);
                addStep("wakeup", 0, '0, bus(6, $urandom), 0);
                addStep("wakeup", 0, '0, bus(5, $urandom), 0);
                addStep("forward", 1, instr(5, waitSrc(7), waitSrc(7), 9), bus(7, $urandom), 0);
                // entry 1 frees early, so the fourth dispatch lands below the third.
                addStep("lowest", 1, instr(7, waitSrc(9), readySrc($urandom), 5), '0, 0);
                addStep("lowest", 1, instr(8, readySrc($urandom), readySrc($urandom), 6), '0, 0);
                addStep("lowest", 1, instr(9, waitSrc(8), readySrc($urandom), 7), '0, 0);
                addStep("lowest", 1, instr(10, readySrc($urandom), waitSrc(8), 8), '0, 0);
                addStep("lowest", 0, '0, bus(8, $urandom), 1);
                addStep("lowest", 0, '0, bus(9, $urandom), 1);
                for (int i = 0; i < 4; i++) begin
                        addStep("backpressure", 1,
                                instr(11 + i, readySrc($urandom), readySrc($urandom), i), '0, 0);
                end
                addStep("backpressure", 0, '0, '0, 0);
                addStep("backpressure", 0, '0, '0, 0);
                addStep("backpressure", 0, '0, '0, 1);
                for (int i = 0; i < `RS_SIZE; i++) begin
                        addStep("fill", 1, instr(15, waitSrc(10), readySrc($urandom), i), '0, 0);
                end
                addStep("fill", 0, '0, bus(10, $urandom), 0);
        endtask

        ////////////////////////////////////////
        // checks and model

        task automatic compareIssue(input string name, input issueT exp, input issueT act);
                if (act !== exp) begin
                        $display("Fail %s: issue expected %h, actual %h", name, exp, act);
                        errors++;
                end
        endtask

        task automatic compareFlag(input string name, input logic exp, input logic act);
                if (act !== exp) begin
                        $display("Fail %s: issueValid expected %b, actual %b", name, exp, act);
                        errors++;
                end
        endtask

        task automatic compareCount(input string name, input int exp, input int act);
                if (act != exp) begin
                        $display("Fail %s: count expected %0d, actual %0d", name, exp, act);
                        errors++;
                end
        endtask

        // one clock edge: the lowest ready entry issues, the lowest free entry takes the dispatch.
        task automatic modelEdge(input logic valid, input dispatchT d, input cdbT c,
                                 input logic ret);
                int pick;
                int slot;
                pick = -1;
                slot = -1;
                for (int i = 0; i < `RS_SIZE; i++) begin
                        if (pick < 0 && mBusy[i] && mEntry[i].srcA.ready && mEntry[i].srcB.ready) begin
                                pick = i;
                        end
                        if (slot < 0 && !mBusy[i]) begin
                                slot = i;
                        end
                end
                expValid = (pick >= 0) && (mCredits > 0);
                if (expValid) begin
                        expIssue.op      = mEntry[pick].op;
                        expIssue.valueA  = mEntry[pick].srcA.operand.data;
                        expIssue.valueB  = mEntry[pick].srcB.operand.data;
                        expIssue.destTag = mEntry[pick].destTag;
                        mBusy[pick]      = 1'b0;
                        mCredits--;
                        issuesExpected++;
                end
                for (int i = 0; i < `RS_SIZE; i++) begin
                        if (mBusy[i]) begin
                                mEntry[i].srcA = snoop(mEntry[i].srcA, c);
                                mEntry[i].srcB = snoop(mEntry[i].srcB, c);
                        end
                end
                if (valid && slot >= 0) begin
                        mBusy[slot]       = 1'b1;
                        mEntry[slot]      = d;
                        mEntry[slot].srcA = snoop(d.srcA, c);
                        mEntry[slot].srcB = snoop(d.srcB, c);
                end
                if (ret) begin
                        mCredits++;
                end
        endtask

        // checks what the last edge produced, then drives one step and advances the model.
        task automatic runCycle(input string name, input logic valid, input dispatchT d,
                                input cdbT c, input logic ret);
                logic doDispatch;
                logic doReturn;
                compareFlag(name, expValid, issueValid);
                if (expValid && issueValid) begin
                        compareIssue(name, expIssue, issue);
                end
                if (issueValid) begin
                        issuesSeen++;
                end
                if (dispatchCredit) begin
                        pulsesSeen++;
                        dispatcherCredits++;
                end
                if (issuesSeen > `ISSUE_CREDITS + returnsSent) begin
                        $display("%s: more issues than the ALU granted credits for", name);
                        errors++;
                end
                doDispatch = valid;
                if (valid && dispatcherCredits == 0) begin
                        $display("%s: the dispatcher had no credit left for a dispatch", name);
                        errors++;
                        doDispatch = 1'b0;
                end
                if (doDispatch) begin
                        dispatcherCredits--;
                end
                if (dispatcherCredits < minDispatchCredits) begin
                        minDispatchCredits = dispatcherCredits;
                end
                // the ALU only returns slots it actually holds.
                doReturn = ret && (issuesSeen > returnsSent);
                if (doReturn) begin
                        returnsSent++;
                end
                dispatchValid     = doDispatch;
                dispatch          = d;
                cdb               = c;
                issueCreditReturn = doReturn;
                modelEdge(doDispatch, d, c, doReturn);
                @(negedge rst);
        endtask

        function automatic logic modelBusy();
                logic any;
                any = 1'b0;
                for (int i = 0; i < `RS_SIZE; i++) begin
                        any = any | mBusy[i];
                end
                return any;
        endfunction

        task automatic drain(input string name);
                while (modelBusy() || expValid || issuesSeen > returnsSent
                       || dispatcherCredits != `RS_SIZE) begin
                        runCycle(name, 1'b0, '0, '0, 1'b1);
                end
        endtask

        ////////////////////////////////////////
        // run

        initial begin
                int errorsBefore;
                dispatchValid      = 1'b0;
                dispatch           = '0;
                cdb                = '0;
                issueCreditReturn  = 1'b0;
                errors             = 0;
                tests              = 0;
                issuesSeen         = 0;
                issuesExpected     = 0;
                pulsesSeen         = 0;
                returnsSent        = 0;
                dispatcherCredits  = `RS_SIZE;
                minDispatchCredits = `RS_SIZE;
                mCredits           = `ISSUE_CREDITS;
                expValid           = 1'b0;
                for (int i = 0; i < `RS_SIZE; i++) begin
                        mBusy[i] = 1'b0;
                end
                void'($urandom(32'hf025_a5de));
                buildTable();
                tableBuilt = 1'b1;
                @(posedge rstN);
                errorsBefore = 0;
                for (int i = 0; i < stepName.size(); i++) begin
                        runCycle(stepName[i], stepValid[i], stepDispatch[i], stepCdb[i],
                                 stepReturn[i]);
                        if (i == stepName.size() - 1 || stepName[i + 1] != stepName[i]) begin
                                drain(stepName[i]);
                                tests++;
                                $display("test %s: %0d errors", stepName[i], errors - errorsBefore);
                                errorsBefore = errors;
                        end
                end
                compareCount("creditPulses", issuesExpected, pulsesSeen);
                compareCount("fillCredits", 0, minDispatchCredits);
                $display("tests %0d, issues %0d, credit pulses %0d, errors %0d",
                         tests, issuesSeen, pulsesSeen, errors);
                if (errors == 0) begin
                        $display("No errors");
                end else begin
                        $display("Errors found");
                end
                $finish;
        end

        // a stuck station or model stops the run here.
        initial begin
                wait (tableBuilt === 1'b1);
                repeat (stepName.size() * 40) @(posedge rst);
                $display("the watchdog stopped the run before all tests finished");
                $display("Errors found");
                $finish;
        end

endmodule

// File: files.f
+incdir+.
rsPkg.sv
freeTagTable.sv
readyPicker.sv
rsArray.sv
rsTop.sv
tbClock.sv
rs_props.sv
rsTb.sv
